/* atm_pager.sv */
// atm-style pager for one 16k window
//  two page settings chosen by 7ffd bit 4
//  registered page/romnram output
//  dos entry/exit strobes and z80 stall stretch
`timescale 1ns/1ps
`include "pager_macros.svh"

module atm_pager #(
	parameter logic [1:0] window = 2'd0 // which 16k window this is
) (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  logic                 zpos,
	input  logic                 zneg,
	input  logic [15:0]          za,
	input  logic                 mreq_n,
	input  logic                 m1_n,
	input  pager_pkg::f7_data_t  f7_data,
	input  logic                 atmF7_wr,
	input  logic                 pager_off,
	input  logic                 pent1m_ROM,
	input  logic [5:0]           pent1m_page,
	input  logic                 pent1m_ram0_0,
	input  logic                 pent1m_1m_on,
	input  logic                 dos,
	output logic [7:0]           page,
	output logic                 romnram,
	output logic                 dos_turn_on,
	output logic                 dos_turn_off,
	output logic                 zclk_stall
);
	import pager_pkg::*;

	logic [1:0][7:0] pages;    // stored inverted, indexed by pent1m_ROM
	logic [1:0]      ramnrom;  // 1 = ram
	logic [1:0]      dos_7ffd; // ram: 7ffd paging, rom: dos bit in page
	logic            win_hit;
	logic            m1_n_reg;
	logic            mreq_n_reg;
	logic            new_m1;   // first zneg of an m1 memory cycle here
	logic [2:0]      stall_count;
	logic [7:0]      cur_page;

	assign win_hit  = (za[15:14] == window);
	assign cur_page = pages[pent1m_ROM];

	// xxf7 write into the setting chosen by 7ffd bit 4
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pages    <= '0;
			ramnrom  <= '0;
			dos_7ffd <= '0;
		end
		else if (atmF7_wr && win_hit)
		begin
			if (za[11]) // 1m form
			begin
				pages[pent1m_ROM]    <= ~{2'b11, f7_data.f1m.page};
				ramnrom[pent1m_ROM]  <= f7_data.f1m.ram;
				dos_7ffd[pent1m_ROM] <= f7_data.f1m.dos_7ffd;
			end
			else // 4m form, always ram
			begin
				pages[pent1m_ROM]   <= ~f7_data.page4m;
				ramnrom[pent1m_ROM] <= 1'b1;
				// dos_7ffd kept, so 7ffd paging also works across 4m
			end
		end
	end

	// page mapping, first matching rule wins
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			page    <= `PAGE_OFF;
			romnram <= 1'b1;
		end
		else if (pager_off)
		begin
			page    <= `PAGE_OFF; // service rom everywhere
			romnram <= 1'b1;
		end
		else if ((window == 2'd0) && pent1m_ram0_0)
		begin
			page    <= 8'd0; // pentagon ram0 in window 0
			romnram <= 1'b0;
		end
		else
		begin
			romnram <= ~ramnrom[pent1m_ROM];
			if (dos_7ffd[pent1m_ROM] && ramnrom[pent1m_ROM])
			begin
				if (pent1m_1m_on)
					page <= {cur_page[7:6], pent1m_page};      // whole 1m from 7ffd
				else
					page <= {cur_page[7:3], pent1m_page[2:0]}; // 128k as in atm2
			end
			else if (dos_7ffd[pent1m_ROM])
				page <= {cur_page[7:1], dos}; // rom map, dos picks the half
			else
				page <= cur_page;
		end
	end

	// bus tracking for m1 detection
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m1_n_reg   <= 1'b1;
			mreq_n_reg <= 1'b1;
		end
		else
		begin
			if (zpos)
				m1_n_reg <= m1_n;
			if (zneg)
				mreq_n_reg <= mreq_n; // previous mreq_n at zneg
		end
	end

	assign new_m1 = zneg && win_hit && !m1_n_reg && !mreq_n && mreq_n_reg;

	// entry only from the rom-with-7ffd setting of the rom map
	assign dos_turn_on  = new_m1 && (za[13:8] == 6'(`DOS_ENTRY_HI)) &&
	                      dos_7ffd[1] && !ramnrom[1] && pent1m_ROM;
	assign dos_turn_off = new_m1 && ramnrom[pent1m_ROM]; // any fetch from ram

	// stall stretch: 000 idle, 101 -> 110 -> 111 -> 000
	// gives the rom time to present data from the new page
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall_count <= 3'b000;
		else if (dos_turn_on)
			stall_count <= 3'b101;
		else if (stall_count[2])
			stall_count <= stall_count + 3'd1;
	end

	assign zclk_stall = dos_turn_on | stall_count[2]; // pulse cycle plus three

endmodule

/* dos_ctrl.sv */
// dos state flag
// set by any window's entry strobe, cleared by any exit strobe
`timescale 1ns/1ps

module dos_ctrl (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic [3:0] turn_on,
	input  logic [3:0] turn_off,
	output logic       dos
);
	logic any_on;
	logic any_off;

	assign any_on  = |turn_on;
	assign any_off = |turn_off;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (any_on)
			dos <= 1'b1; // entry wins on a tie
		else if (any_off)
			dos <= 1'b0;
	end

endmodule

/* mem_addr_gen.sv */
// memory address former
//  picks the window of za[15:14]
//  two register stages to mem_addr and rom_sel
`timescale 1ns/1ps
`include "pager_macros.svh"

module mem_addr_gen (
	input  logic                                fclk,
	input  logic                                rst_n,
	input  logic [15:0]                         za,
	input  logic [`PAGER_WINDOWS-1:0][7:0]      pages,
	input  logic [`PAGER_WINDOWS-1:0]           romnram,
	output pager_pkg::mem_addr_t                mem_addr,
	output logic                                rom_sel
);
	import pager_pkg::*;

	localparam int WW = $clog2(`PAGER_WINDOWS);

	logic [WW-1:0] win_q; // window of the latched address
	logic [13:0]   ofs_q;
	mem_addr_t     addr_d;

	assign addr_d = {pages[win_q], ofs_q};

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			win_q   <= '0;
			rom_sel <= 1'b1; // service rom until paging is set up
		end
		else
		begin
			win_q   <= za[15:14];
			rom_sel <= romnram[win_q];
		end
	end

	always_ff @(posedge fclk)
	begin
		ofs_q    <= za[13:0];
		mem_addr <= addr_d; // page:offset
	end

endmodule

/* memory_pager_top.sv */
// atm turbo 2 / pentagon 1024 memory pager
//  port decoder, four window pagers, z80 phase strobes,
//  dos flag and memory address former
`timescale 1ns/1ps
`include "pager_macros.svh"

module memory_pager_top (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  logic [15:0]          za,
	input  logic [7:0]           zd,
	input  logic                 mreq_n,
	input  logic                 iorq_n,
	input  logic                 wr_n,
	input  logic                 rd_n,
	input  logic                 m1_n,
	output pager_pkg::mem_addr_t mem_addr,
	output logic                 rom_sel,
	output logic                 dos,
	output logic                 zpos,
	output logic                 zneg,
	output logic                 zclk_stall
);
	import pager_pkg::*;

	logic                            atmF7_wr;
	f7_data_t                        f7_data;
	logic                            pent1m_ROM;
	logic [5:0]                      pent1m_page;
	logic                            pent1m_ram0_0;
	logic                            pent1m_1m_on;
	logic                            pager_off;
	logic [`PAGER_WINDOWS-1:0][7:0]  pages;    // per-window page
	logic [`PAGER_WINDOWS-1:0]       romnram;
	logic [`PAGER_WINDOWS-1:0]       turn_on;  // dos entry strobes
	logic [`PAGER_WINDOWS-1:0]       turn_off; // dos exit strobes
	logic [`PAGER_WINDOWS-1:0]       stall;

	port_decode u_port_decode (
		.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .za(za), .zd(zd),
		.iorq_n(iorq_n), .wr_n(wr_n), .rd_n(rd_n),
		.atmF7_wr(atmF7_wr), .f7_data(f7_data),
		.pent1m_ROM(pent1m_ROM), .pent1m_page(pent1m_page),
		.pent1m_ram0_0(pent1m_ram0_0), .pent1m_1m_on(pent1m_1m_on),
		.pager_off(pager_off)
	);

	for (genvar w = 0; w < `PAGER_WINDOWS; w++)
	begin : g_pager
		atm_pager #(.window(2'(w))) u_pager (
			.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .zneg(zneg), .za(za),
			.mreq_n(mreq_n), .m1_n(m1_n), .f7_data(f7_data), .atmF7_wr(atmF7_wr),
			.pager_off(pager_off), .pent1m_ROM(pent1m_ROM),
			.pent1m_page(pent1m_page), .pent1m_ram0_0(pent1m_ram0_0),
			.pent1m_1m_on(pent1m_1m_on), .dos(dos),
			.page(pages[w]), .romnram(romnram[w]),
			.dos_turn_on(turn_on[w]), .dos_turn_off(turn_off[w]),
			.zclk_stall(stall[w])
		);
	end

	z80_strobes u_strobes (
		.fclk(fclk), .rst_n(rst_n), .stall(stall),
		.zpos(zpos), .zneg(zneg), .zclk_stall(zclk_stall)
	);

	dos_ctrl u_dos (
		.fclk(fclk), .rst_n(rst_n), .turn_on(turn_on), .turn_off(turn_off), .dos(dos)
	);

	mem_addr_gen u_addr (
		.fclk(fclk), .rst_n(rst_n), .za(za), .pages(pages), .romnram(romnram),
		.mem_addr(mem_addr), .rom_sel(rom_sel)
	);

endmodule

/* pager_macros.svh */
// pager build constants
// window count, z80 clock divide, dos entry area, reset values
`ifndef PAGER_MACROS_SVH
`define PAGER_MACROS_SVH

`define PAGER_WINDOWS   4      // 16k windows over the z80 space
`define ZCLK_DIV        4      // fclk cycles per z80 clock

`define DOS_ENTRY_HI    8'h3D  // dos rom entry area, high addr byte in window
`define PAGE_OFF        8'hFF  // service rom page while paging is off

// control register values after reset
`define PAGER_OFF_RST   1'b1   // paging off, service rom everywhere
`define PENT_1M_ON_RST  1'b1   // eff7 bit 2 clear -> 1m mode

`endif

/* pager_pkg.sv */
// pager types
//  f7_data_t  - xxf7 data byte, 4m and 1m forms
//  mem_addr_t - 22-bit memory address
package pager_pkg;

	// xxf7 byte as written by the cpu
	// za[11]=0 -> 4m form, whole byte is the page
	// za[11]=1 -> 1m form, page in low 6 bits plus two flags
	typedef union packed
	{
		logic [7:0] page4m;
		struct packed
		{
			logic       dos_7ffd; // 7ffd bits drive this window
			logic       ram;      // 1 = ram, 0 = rom
			logic [5:0] page;
		} f1m;
	} f7_data_t;

	// {page[7:0], offset[13:0]}
	typedef logic [21:0] mem_addr_t;

endpackage

/* port_decode.sv */
// z80 port write decoder
//  7ffd, eff7, xx77 control registers
//  xxf7 write pulse with held data byte
`timescale 1ns/1ps
`include "pager_macros.svh"

module port_decode (
	input  logic                fclk,
	input  logic                rst_n,
	input  logic                zpos,
	input  logic [15:0]         za,
	input  logic [7:0]          zd,
	input  logic                iorq_n,
	input  logic                wr_n,
	input  logic                rd_n,
	output logic                atmF7_wr,
	output pager_pkg::f7_data_t f7_data,
	output logic                pent1m_ROM,
	output logic [5:0]          pent1m_page,
	output logic                pent1m_ram0_0,
	output logic                pent1m_1m_on,
	output logic                pager_off
);
	import pager_pkg::*;

	logic io_wr;     // io write cycle on the bus
	logic io_done;   // this cycle already decoded
	logic io_wr_stb; // first zpos of the write
	logic is_7ffd;
	logic is_eff7;
	logic is_77;
	logic is_f7;

	assign io_wr     = !iorq_n && !wr_n && rd_n;
	assign io_wr_stb = zpos && io_wr && !io_done;

	assign is_7ffd = !za[15] && (za[7:0] == 8'hFD);
	assign is_eff7 = (za == 16'hEFF7);
	assign is_77   = (za[7:0] == 8'h77);
	assign is_f7   = (za[7:0] == 8'hF7) && (za[13:12] == 2'b11) && (za[10:8] == 3'b111);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_done <= 1'b0;
		else if (iorq_n)
			io_done <= 1'b0; // cycle over, rearm
		else if (io_wr_stb)
			io_done <= 1'b1;
	end

	// pentagon and atm control state
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pent1m_ROM    <= 1'b0;
			pent1m_page   <= 6'd0;
			pent1m_ram0_0 <= 1'b0;
			pent1m_1m_on  <= `PENT_1M_ON_RST;
			pager_off     <= `PAGER_OFF_RST;
			atmF7_wr      <= 1'b0;
		end
		else
		begin
			atmF7_wr <= io_wr_stb && is_f7; // one fclk wide
			if (io_wr_stb && is_7ffd)
			begin
				pent1m_page <= {zd[7:5], zd[2:0]};
				pent1m_ROM  <= zd[4];
			end
			if (io_wr_stb && is_eff7)
			begin
				pent1m_ram0_0 <= zd[3];
				pent1m_1m_on  <= !zd[2];
			end
			if (io_wr_stb && is_77)
				pager_off <= !zd[0]; // bit 0 = pager enable
		end
	end

	// xxf7 byte, held for the pagers
	always_ff @(posedge fclk)
	begin
		if (io_wr_stb && is_f7)
			f7_data.page4m <= zd;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the pager testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_memory_pager -o sim_pager

out=$(./obj_dir/sim_pager 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
	exit 0
fi
exit 1

/* src.f */
+incdir+.
pager_pkg.sv
port_decode.sv
atm_pager.sv
z80_strobes.sv
dos_ctrl.sv
mem_addr_gen.sv
memory_pager_top.sv
tb_memory_pager.sv

/* tb_memory_pager.sv */
// testbench for the memory pager
//  clock, reset, watchdog, stall and phase monitors
//  z80 bus tasks (io write, memory fetch, address read)
//  six directed tests over ports, page maps and dos entry/exit
`timescale 1ns/1ps
`include "pager_macros.svh"

module tb_memory_pager;

	localparam int CLK_PERIOD      = 40;
	localparam int TEST_Z80_CYCLES = 110; // upper bound summed over all tests
	localparam int WATCHDOG_NS     = TEST_Z80_CYCLES * `ZCLK_DIV * CLK_PERIOD * 2;

	logic        fclk;
	logic        rst_n;
	logic [15:0] za;
	logic [7:0]  zd;
	logic        mreq_n;
	logic        iorq_n;
	logic        wr_n;
	logic        rd_n;
	logic        m1_n;
	logic [21:0] mem_addr;
	logic        rom_sel;
	logic        dos;
	logic        zpos;
	logic        zneg;
	logic        zclk_stall;

	logic [31:0] rng = 32'h968f_8168;
	int          stall_total = 0; // fclk cycles seen with zclk_stall high
	int          since_zpos = 0;  // fclk cycles since the last zpos
	string       test_name = "none";
	logic [7:0]  rom_page; // stored window 0 rom setting, kept for the dos tests

	memory_pager_top u_dut (
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd(zd), .mreq_n(mreq_n),
		.iorq_n(iorq_n), .wr_n(wr_n), .rd_n(rd_n), .m1_n(m1_n),
		.mem_addr(mem_addr), .rom_sel(rom_sel), .dos(dos),
		.zpos(zpos), .zneg(zneg), .zclk_stall(zclk_stall)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		rng = xorshift(rng);
		b = rng[7:0];
	endtask

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("FAILED %s %s expected %0h actual %0h", test_name, name, exp, act);
			stop_run("stopping at the first mismatch");
		end
	endtask

	// xxf7 port for a window, form bit is za[11]
	function automatic logic [15:0] f7_port(input logic [1:0] w, input logic form1m);
		return {w, 2'b11, form1m, 3'b111, 8'hF7};
	endfunction

	// next zpos, sampled clear of the edge
	task automatic wait_zpos();
		do
		begin
			@(posedge fclk);
			#2;
		end
		while (!zpos);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		wait_zpos();
		za     = addr;
		zd     = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		wait_zpos(); // one z80 cycle
		iorq_n = 1'b1;
		wr_n   = 1'b1;
	endtask

	// m1 = 1 for an opcode fetch, 0 for a plain read
	task automatic mem_fetch(input logic [15:0] addr, input logic m1);
		wait_zpos();
		za     = addr;
		m1_n   = !m1;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		wait_zpos(); // stretched by any stall
		m1_n   = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	task automatic read_addr(input logic [15:0] a, output logic [7:0] pg, output logic rs);
		za = a;
		repeat (3) @(posedge fclk);
		#2;
		pg = mem_addr[21:14];
		rs = rom_sel;
		check("offset", 32'(a[13:0]), 32'(mem_addr[13:0]));
	endtask

	task automatic test_reset();
		logic [7:0] pg;
		logic       rs;
		test_name = "reset";
		for (int w = 0; w < `PAGER_WINDOWS; w++)
		begin
			read_addr({2'(w), 14'h0A5A}, pg, rs);
			check("page", 32'(`PAGE_OFF), 32'(pg));
			check("rom_sel", 32'd1, 32'(rs));
		end
		check("dos", 32'd0, 32'(dos));
	endtask

	task automatic test_4m_form();
		logic [7:0] b [2][4];
		logic [7:0] pg;
		logic [7:0] exp_pg;
		logic       rs;
		test_name = "4m_form";
		io_write(16'h0077, 8'h01); // paging on
		for (int s = 0; s < 2; s++)
		begin
			io_write(16'h7FFD, s[0] ? 8'h10 : 8'h00); // pick setting
			for (int w = 0; w < `PAGER_WINDOWS; w++)
			begin
				rand_byte(b[s][w]);
				io_write(f7_port(2'(w), 1'b0), b[s][w]);
			end
		end
		for (int s = 0; s < 2; s++)
		begin
			io_write(16'h7FFD, s[0] ? 8'h10 : 8'h00);
			for (int w = 0; w < `PAGER_WINDOWS; w++)
			begin
				read_addr({2'(w), 14'h2A5C}, pg, rs);
				exp_pg = ~b[s][w]; // pages are stored inverted
				check("page", 32'(exp_pg), 32'(pg));
				check("rom_sel", 32'd0, 32'(rs));
			end
		end
	endtask

	task automatic test_1m_7ffd_ram();
		logic [7:0] v;
		logic [7:0] t;
		logic [5:0] p [4];
		logic [7:0] stored;
		logic [7:0] exp_pg;
		logic [7:0] pg;
		logic       rs;
		test_name = "1m_7ffd_ram";
		rand_byte(v);
		v[4] = 1'b0; // setting 0
		io_write(16'h7FFD, v);
		for (int w = 0; w < `PAGER_WINDOWS; w++)
		begin
			rand_byte(t);
			p[w] = t[5:0];
			io_write(f7_port(2'(w), 1'b1), {1'b1, 1'b1, p[w]}); // 7ffd control, ram
		end
		for (int m = 0; m < 2; m++)
		begin
			if (m == 1)
				io_write(16'hEFF7, 8'h04); // 1m mode off, 128k paging
			for (int w = 0; w < `PAGER_WINDOWS; w++)
			begin
				stored = ~{2'b11, p[w]};
				if (m == 0)
					exp_pg = {stored[7:6], v[7:5], v[2:0]};
				else
					exp_pg = {stored[7:3], v[2:0]};
				read_addr({2'(w), 14'h1357}, pg, rs);
				check("page", 32'(exp_pg), 32'(pg));
				check("rom_sel", 32'd0, 32'(rs));
			end
		end
		io_write(16'hEFF7, 8'h00);
	endtask

	task automatic test_rom_dos();
		logic [7:0] t;
		logic [7:0] exp_pg;
		logic [7:0] pg;
		logic       rs;
		test_name = "rom_dos";
		io_write(16'h7FFD, 8'h10); // setting 1
		rand_byte(t);
		io_write(f7_port(2'd0, 1'b1), {1'b1, 1'b0, t[5:0]}); // rom with 7ffd control
		rom_page = ~{2'b11, t[5:0]};
		exp_pg   = {rom_page[7:1], 1'b0}; // dos still off
		read_addr(16'h0100, pg, rs);
		check("dos", 32'd0, 32'(dos));
		check("page", 32'(exp_pg), 32'(pg));
		check("rom_sel", 32'd1, 32'(rs));
		io_write(16'hEFF7, 8'h08); // ram0 in window 0
		read_addr(16'h0100, pg, rs);
		check("ram0_page", 32'd0, 32'(pg));
		check("ram0_rom_sel", 32'd0, 32'(rs));
		io_write(16'hEFF7, 8'h00);
	endtask

	task automatic test_dos_entry_exit();
		int         stall_before;
		logic [7:0] exp_pg;
		logic [7:0] pg;
		logic       rs;
		test_name = "dos_entry_exit";
		stall_before = stall_total;
		mem_fetch(16'h3D00, 1'b1);
		check("dos_on", 32'd1, 32'(dos));
		check("stall_cycles", 32'd4, 32'(stall_total - stall_before)); // strobe cycle plus three
		exp_pg = {rom_page[7:1], 1'b1};
		read_addr(16'h0100, pg, rs);
		check("page", 32'(exp_pg), 32'(pg));
		check("rom_sel", 32'd1, 32'(rs));
		mem_fetch(16'h4000, 1'b1); // window 1, setting 1 is ram from the 4m test
		check("dos_off", 32'd0, 32'(dos));
	endtask

	task automatic test_plain_read();
		int stall_before;
		test_name = "plain_read";
		stall_before = stall_total;
		mem_fetch(16'h3D00, 1'b0);
		check("dos_kept_off", 32'd0, 32'(dos));
		check("no_stall", 32'd0, 32'(stall_total - stall_before));
		mem_fetch(16'h3D00, 1'b1);
		mem_fetch(16'h4000, 1'b0); // ram read, not a fetch
		check("dos_kept_on", 32'd1, 32'(dos));
	endtask

	// stall length and frozen zpos, sampled mid-cycle
	always @(negedge fclk)
	begin
		if (zclk_stall)
		begin
			stall_total = stall_total + 1;
			check("zpos_in_stall", 32'd0, 32'(zpos));
		end
	end

	// zneg comes half a z80 clock after each zpos
	always @(negedge fclk)
	begin
		if (zpos)
			since_zpos = 0;
		else
		begin
			since_zpos = since_zpos + 1;
			if (zneg)
				check("zneg_phase", 32'(`ZCLK_DIV / 2), 32'(since_zpos));
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		stop_run("timeout: the tests did not finish within the watchdog time");
	end

	initial
	begin
		rst_n  = 1'b0;
		za     = 16'h0000;
		zd     = 8'h00;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		rd_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (4) @(posedge fclk);
		#2;
		rst_n = 1'b1;
		test_reset();
		test_4m_form();
		test_1m_7ffd_ram();
		test_rom_dos();
		test_dos_entry_exit();
		test_plain_read();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* z80_strobes.sv */
// z80 clock phase generator
//  zpos at phase 0, zneg at half period
//  phase frozen while any pager stalls
`timescale 1ns/1ps
`include "pager_macros.svh"

module z80_strobes (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic [3:0] stall,      // one request per window
	output logic       zpos,
	output logic       zneg,
	output logic       zclk_stall
);
	localparam int PW = $clog2(`ZCLK_DIV);

	logic [PW-1:0] phase;
	logic [PW-1:0] phase_nxt;

	assign zclk_stall = |stall;
	assign phase_nxt  = (phase == PW'(`ZCLK_DIV - 1)) ? '0 : phase + 1'b1;

	// strobes registered so they mark the phase the counter moves into
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= '0;
			zpos  <= 1'b1; // start at phase 0
			zneg  <= 1'b0;
		end
		else if (zclk_stall)
		begin
			zpos <= 1'b0; // hold phase, no edges
			zneg <= 1'b0;
		end
		else
		begin
			phase <= phase_nxt;
			zpos  <= (phase_nxt == '0);
			zneg  <= (phase_nxt == PW'(`ZCLK_DIV / 2));
		end
	end

endmodule
